// ==== src/ppu_pkg.sv ====
/* PPU shared package
   Types, VGA and PPU timing, register indices and colour tables */

package ppu_pkg;

    // ----------------------------------------
    // Vector types
    // ----------------------------------------
    typedef logic [9:0]  beam_pos_t;
    typedef logic [8:0]  ppu_coord_t;
    typedef logic [5:0]  color_idx_t;
    // Bit 4 selects the sprite half
    typedef logic [4:0]  pal_addr_t;
    typedef logic [14:0] vram_addr_t;
    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;
    typedef logic [3:0]  rgb_chan_t;

    // ----------------------------------------
    // VGA 800 x 525 frame
    // ----------------------------------------
    localparam beam_pos_t H_VISIBLE = 10'd640;
    localparam beam_pos_t H_FRONT   = 10'd16;
    localparam beam_pos_t H_SYNC    = 10'd96;
    localparam beam_pos_t H_BACK    = 10'd48;
    // Sync pulse sits at the end of the line
    localparam beam_pos_t H_SYNC_START = H_BACK + H_VISIBLE + H_FRONT;
    localparam beam_pos_t H_TOTAL      = H_SYNC_START + H_SYNC;

    localparam beam_pos_t V_VISIBLE = 10'd480;
    localparam beam_pos_t V_FRONT   = 10'd10;
    localparam beam_pos_t V_SYNC    = 10'd2;
    localparam beam_pos_t V_BACK    = 10'd33;
    localparam beam_pos_t V_SYNC_START = V_BACK + V_VISIBLE + V_FRONT;
    localparam beam_pos_t V_TOTAL      = V_SYNC_START + V_SYNC;

    // ----------------------------------------
    // PPU 341 x 262 timing
    // ----------------------------------------
    localparam ppu_coord_t PPU_DOTS     = 9'd341;
    localparam ppu_coord_t PPU_DOT_LAST = PPU_DOTS - 9'd1;
    // Two VGA clocks per dot
    localparam beam_pos_t  PPU_WINDOW   = beam_pos_t'(2 * PPU_DOTS);
    localparam beam_pos_t  PPU_X_START  = H_BACK;
    localparam beam_pos_t  PPU_X_END    = H_BACK + PPU_WINDOW;

    localparam ppu_coord_t VBLANK_LINE    = 9'd257;
    localparam ppu_coord_t VBLANK_DOT     = 9'd1;
    localparam ppu_coord_t PRERENDER_LINE = 9'd16;

    // Dots per CPU slot
    localparam logic [1:0] CPU_DIVIDE = 2'd3;

    // ----------------------------------------
    // CPU registers at $2000
    // ----------------------------------------
    localparam logic [2:0] REG_CTRL   = 3'd0;
    localparam logic [2:0] REG_MASK   = 3'd1;
    localparam logic [2:0] REG_STATUS = 3'd2;
    localparam logic [2:0] REG_ADDR   = 3'd6;
    localparam logic [2:0] REG_DATA   = 3'd7;

    localparam cpu_data_t CTRL_RESET   = 8'h10;
    localparam cpu_data_t MASK_RESET   = 8'h0E;
    localparam cpu_data_t STATUS_FIXED = 8'b0001_0000;

    // ----------------------------------------
    // Palette and colour
    // ----------------------------------------
    localparam vram_addr_t PALETTE_BASE = 15'h3F00;
    localparam vram_addr_t PALETTE_END  = 15'h3F20;
    localparam int         PAL_ENTRIES  = 32;
    localparam color_idx_t COLOR_BLANK  = 6'h3F;

    // Background half, then sprite half
    localparam color_idx_t PAL_RESET [PAL_ENTRIES] = '{
        6'h0F, 6'h16, 6'h30, 6'h38, 6'h00, 6'h16, 6'h26, 6'h07,
        6'h00, 6'h26, 6'h00, 6'h30, 6'h00, 6'h38, 6'h28, 6'h10,
        6'h0F, 6'h16, 6'h27, 6'h12, 6'h0F, 6'h30, 6'h2B, 6'h16,
        6'h0F, 6'h39, 6'h28, 6'h27, 6'h0F, 6'h30, 6'h30, 6'h30
    };

    // Colour index to 12-bit RGB, four bits per channel
    localparam logic [11:0] RGB_TABLE [64] = '{
        12'h777, 12'h218, 12'h00A, 12'h409, 12'h807, 12'hA01, 12'hA00, 12'h700,
        12'h420, 12'h040, 12'h050, 12'h031, 12'h135, 12'h000, 12'h000, 12'h000,
        12'hBBB, 12'h07E, 12'h23E, 12'h80F, 12'hB0B, 12'hE05, 12'hD20, 12'hC40,
        12'h870, 12'h090, 12'h0A0, 12'h093, 12'h088, 12'h000, 12'h000, 12'h000,
        12'hFFF, 12'h3BF, 12'h59F, 12'hA8F, 12'hF7F, 12'hF7B, 12'hF76, 12'hF93,
        12'hFB3, 12'h8D1, 12'h4D4, 12'h5F9, 12'h0ED, 12'h000, 12'h000, 12'h000,
        12'hFFF, 12'hAEF, 12'hCDF, 12'hDCF, 12'hFCF, 12'hFCD, 12'hFBB, 12'hFDA,
        12'hFEA, 12'hEFA, 12'hAFB, 12'hBFC, 12'h9FF, 12'h000, 12'h000, 12'h000
    };

endpackage

// ==== src/ppu_if.sv ====
/* PPU internal buses
   Beam position from the timing block, palette port from the register file */

`timescale 1ns/1ps

interface ppu_beam_if import ppu_pkg::*; ();

    // One clock per PPU dot
    logic       dot_en;
    ppu_coord_t px;
    ppu_coord_t py;
    // Beam inside the 640 x 480 window
    logic       active;

    modport source  (output dot_en, output px, output py, output active);
    modport regs    (input dot_en, input px, input py);
    modport display (input active);

endinterface

interface palette_bus_if import ppu_pkg::*; ();

    // Write on the edge where we is high
    logic      we;
    pal_addr_t addr;
    cpu_data_t wdata;
    // Combinational from addr
    cpu_data_t rdata;

    modport master (output we, output addr, output wdata, input rdata);
    modport mem    (input we, input addr, input wdata, output rdata);

endinterface

// ==== src/vga_timing.sv ====
/* VGA timing generator
   Beam counters and sync, plus the PPU dot strobe and dot/line counters */

`timescale 1ns/1ps

module vga_timing import ppu_pkg::*; (
    input  logic      clock25,
    input  logic      reset_n,
    output logic      hs_o,
    output logic      vs_o,
    ppu_beam_if.source beam
);

    beam_pos_t  x_q;
    beam_pos_t  y_q;
    ppu_coord_t px_q;
    ppu_coord_t py_q;
    logic       x_last;
    logic       y_last;
    logic       dot_en;

    // ----------------------------------------
    // Frame limits and sync
    // ----------------------------------------
    assign x_last = (x_q == H_TOTAL - 10'd1);
    assign y_last = (y_q == V_TOTAL - 10'd1);

    // Negative sync pulses at the end of line and frame
    assign hs_o = (x_q < H_SYNC_START);
    assign vs_o = (y_q < V_SYNC_START);

    // Visible window after the back porch
    assign beam.active = (x_q >= H_BACK) && (x_q < H_BACK + H_VISIBLE) &&
                         (y_q >= V_BACK) && (y_q < V_BACK + V_VISIBLE);

    // One PPU dot per VGA clock pair, odd lines only
    assign dot_en = x_q[0] && y_q[0] && (x_q >= PPU_X_START) && (x_q < PPU_X_END);

    assign beam.dot_en = dot_en;
    assign beam.px     = px_q;
    assign beam.py     = py_q;

    // ----------------------------------------
    // Counters
    // ----------------------------------------
    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            x_q  <= '0;
            y_q  <= '0;
            px_q <= '0;
            py_q <= '0;
        end else begin
            x_q <= x_last ? '0 : x_q + 10'd1;
            if (x_last) begin
                y_q <= y_last ? '0 : y_q + 10'd1;
            end

            // Last VGA line restarts the PPU frame
            if (y_last) begin
                px_q <= '0;
                py_q <= '0;
            end else if (x_last) begin
                px_q <= '0;
            end else if (dot_en) begin
                // Line advances after dot 340
                if (px_q == PPU_DOT_LAST) begin
                    px_q <= '0;
                    py_q <= py_q + 9'd1;
                end else begin
                    px_q <= px_q + 9'd1;
                end
            end
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // Dots sit on odd x only, so never on two clocks in a row
    a_dot_odd_x: assert property (@(posedge clock25) disable iff (!reset_n)
        dot_en |=> !dot_en);

    a_px_range: assert property (@(posedge clock25) disable iff (!reset_n)
        dot_en |=> px_q <= PPU_DOT_LAST);

endmodule

// ==== src/ppu_cpu_regs.sv ====
/* PPU CPU register file
   CPU slot sequencing, $2000-$2007 decode, VRAM address latch, vblank and NMI */

`timescale 1ns/1ps

module ppu_cpu_regs import ppu_pkg::*; (
    input  logic          clock25,
    input  logic          reset_n,
    ppu_beam_if.regs      beam,
    palette_bus_if.master pal,
    input  cpu_addr_t     cpu_addr_i,
    input  cpu_data_t     cpu_wdata_i,
    input  logic          cpu_we_i,
    input  logic          cpu_re_i,
    output cpu_data_t     cpu_rdata_o,
    output logic          ce_cpu_o,
    output logic          nmi_o
);

    logic [1:0] phase_q;
    cpu_data_t  ctrl_q;
    cpu_data_t  mask_q;
    cpu_data_t  rd_hold_q;
    vram_addr_t vaddr_q;
    vram_addr_t vaddr_step;
    logic       toggle_q;
    logic       vblank_q;
    logic       rd_pending_q;
    logic       exec_dot;
    logic       resp_dot;
    logic       reg_sel;
    logic       in_palette;
    logic       data_access;
    logic       vblank_set;
    logic       vblank_clear;
    logic [2:0] reg_idx;
    cpu_data_t  rd_value;

    // ----------------------------------------
    // Slot phases: 0 pulse, 1 execute, 2 answer
    // ----------------------------------------
    assign exec_dot = beam.dot_en && (phase_q == 2'd1);
    assign resp_dot = beam.dot_en && (phase_q == 2'd2);

    // Registers mirror across $2000-$3FFF
    assign reg_sel     = (cpu_addr_i[15:13] == 3'b001);
    assign reg_idx     = cpu_addr_i[2:0];
    assign data_access = reg_sel && (reg_idx == REG_DATA) && (cpu_we_i || cpu_re_i);

    // Only the palette lives behind $2007
    assign in_palette = (vaddr_q >= PALETTE_BASE) && (vaddr_q < PALETTE_END);
    assign vaddr_step = ctrl_q[2] ? 15'd32 : 15'd1;

    assign vblank_set   = beam.dot_en && (beam.py == VBLANK_LINE) && (beam.px == VBLANK_DOT);
    assign vblank_clear = beam.dot_en && (beam.py == PRERENDER_LINE) && (beam.px == VBLANK_DOT);

    assign pal.addr  = vaddr_q[4:0];
    assign pal.wdata = cpu_wdata_i;
    assign pal.we    = exec_dot && reg_sel && (reg_idx == REG_DATA) && cpu_we_i && in_palette;

    // Read mux, unmapped reads give 0
    always_comb begin
        rd_value = '0;
        if (reg_sel) begin
            case (reg_idx)
                REG_CTRL:   rd_value = ctrl_q;
                REG_MASK:   rd_value = mask_q;
                // Sprite hit and overflow stay 0
                REG_STATUS: rd_value = STATUS_FIXED | {vblank_q, 7'b0};
                REG_DATA:   rd_value = in_palette ? pal.rdata : '0;
                default:    rd_value = '0;
            endcase
        end
    end

    // ----------------------------------------
    // Control state
    // ----------------------------------------
    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            phase_q      <= '0;
            ce_cpu_o     <= 1'b0;
            ctrl_q       <= CTRL_RESET;
            mask_q       <= MASK_RESET;
            vaddr_q      <= '0;
            toggle_q     <= 1'b0;
            vblank_q     <= 1'b0;
            nmi_o        <= 1'b0;
            rd_pending_q <= 1'b0;
            cpu_rdata_o  <= '0;
        end else begin
            // Pulse follows the phase 0 dot
            ce_cpu_o <= beam.dot_en && (phase_q == 2'd0);
            if (beam.dot_en) begin
                phase_q <= (phase_q == CPU_DIVIDE - 2'd1) ? 2'd0 : phase_q + 2'd1;
            end

            if (exec_dot && reg_sel && cpu_we_i) begin
                case (reg_idx)
                    REG_CTRL: ctrl_q <= cpu_wdata_i;
                    REG_MASK: mask_q <= cpu_wdata_i;
                    // High byte first, then low byte
                    REG_ADDR: begin
                        if (!toggle_q) begin
                            vaddr_q[14:8] <= cpu_wdata_i[6:0];
                        end else begin
                            vaddr_q[7:0] <= cpu_wdata_i;
                        end
                        toggle_q <= !toggle_q;
                    end
                    default: ;
                endcase
            end else if (exec_dot && reg_sel && cpu_re_i && (reg_idx == REG_STATUS)) begin
                // Status read acknowledges vblank
                vblank_q <= 1'b0;
                toggle_q <= 1'b0;
            end

            // Address steps on every data port access
            if (exec_dot && data_access) begin
                vaddr_q <= vaddr_q + vaddr_step;
            end

            // Read result goes out one dot later
            if (exec_dot && cpu_re_i) begin
                rd_pending_q <= 1'b1;
            end else if (resp_dot && rd_pending_q) begin
                rd_pending_q <= 1'b0;
                cpu_rdata_o  <= rd_hold_q;
            end

            // Vblank edges override a status read on the same dot
            if (vblank_set) begin
                vblank_q <= 1'b1;
                nmi_o    <= ctrl_q[7];
            end else if (vblank_clear) begin
                vblank_q <= 1'b0;
                nmi_o    <= 1'b0;
            end
        end
    end

    // Captured read value
    always_ff @(posedge clock25) begin
        if (exec_dot && cpu_re_i) begin
            rd_hold_q <= rd_value;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_ce_single: assert property (@(posedge clock25) disable iff (!reset_n)
        ce_cpu_o |=> !ce_cpu_o);

    a_nmi_enabled: assert property (@(posedge clock25) disable iff (!reset_n)
        $rose(nmi_o) |-> $past(ctrl_q[7]));

endmodule

// ==== src/ppu_palette.sv ====
/* PPU palette memory
   16 background and 16 sprite entries, CPU port and backdrop output */

`timescale 1ns/1ps

module ppu_palette import ppu_pkg::*; (
    input  logic        clock25,
    input  logic        reset_n,
    palette_bus_if.mem  pal,
    output color_idx_t  backdrop_o
);

    // Entries 0-15 background, 16-31 sprites
    color_idx_t mem_q [PAL_ENTRIES];

    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            // Power-on palette
            for (int i = 0; i < PAL_ENTRIES; i++) begin
                mem_q[i] <= PAL_RESET[i];
            end
        end else if (pal.we) begin
            // Only six bits are stored
            mem_q[pal.addr] <= pal.wdata[5:0];
        end
    end

    // Upper data bits read as 0
    assign pal.rdata = {2'b00, mem_q[pal.addr]};

    // Universal background colour
    assign backdrop_o = mem_q[0];

endmodule

// ==== src/ppu_color_out.sv ====
/* PPU colour output
   Picks backdrop or blank per pixel and maps the index to 12-bit RGB */

`timescale 1ns/1ps

module ppu_color_out import ppu_pkg::*; (
    input  logic           clock25,
    input  logic           reset_n,
    ppu_beam_if.display    beam,
    input  color_idx_t     backdrop_i,
    output rgb_chan_t      r_o,
    output rgb_chan_t      g_o,
    output rgb_chan_t      b_o
);

    color_idx_t  cl_q;
    logic [11:0] rgb;

    // ----------------------------------------
    // Index register, one clock behind the beam
    // ----------------------------------------
    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            cl_q <= COLOR_BLANK;
        end else if (beam.active) begin
            // Backdrop fills the whole window
            cl_q <= backdrop_i;
        end else begin
            // Blanking is black
            cl_q <= COLOR_BLANK;
        end
    end

    // Table lookup
    assign rgb = RGB_TABLE[cl_q];

    // R in the top nibble, B in the bottom
    assign r_o = rgb[11:8];
    assign g_o = rgb[7:4];
    assign b_o = rgb[3:0];

endmodule

// ==== src/ppu_top.sv ====
/* PPU top level
   Timing, CPU registers, palette and colour output on plain ports */

`timescale 1ns/1ps

module ppu_top import ppu_pkg::*; (
    input  logic      clock25,
    input  logic      reset_n,
    // CPU side
    input  cpu_addr_t cpu_addr_i,
    input  cpu_data_t cpu_wdata_i,
    input  logic      cpu_we_i,
    input  logic      cpu_re_i,
    output cpu_data_t cpu_rdata_o,
    output logic      ce_cpu_o,
    output logic      nmi_o,
    // VGA side
    output rgb_chan_t r_o,
    output rgb_chan_t g_o,
    output rgb_chan_t b_o,
    output logic      hs_o,
    output logic      vs_o
);

    color_idx_t backdrop;

    ppu_beam_if    beam ();
    palette_bus_if pal ();

    vga_timing u_timing (
        .clock25 (clock25),
        .reset_n (reset_n),
        .hs_o    (hs_o),
        .vs_o    (vs_o),
        .beam    (beam.source)
    );

    ppu_cpu_regs u_regs (
        .clock25     (clock25),
        .reset_n     (reset_n),
        .beam        (beam.regs),
        .pal         (pal.master),
        .cpu_addr_i  (cpu_addr_i),
        .cpu_wdata_i (cpu_wdata_i),
        .cpu_we_i    (cpu_we_i),
        .cpu_re_i    (cpu_re_i),
        .cpu_rdata_o (cpu_rdata_o),
        .ce_cpu_o    (ce_cpu_o),
        .nmi_o       (nmi_o)
    );

    ppu_palette u_palette (
        .clock25    (clock25),
        .reset_n    (reset_n),
        .pal        (pal.mem),
        .backdrop_o (backdrop)
    );

    ppu_color_out u_color (
        .clock25    (clock25),
        .reset_n    (reset_n),
        .beam       (beam.display),
        .backdrop_i (backdrop),
        .r_o        (r_o),
        .g_o        (g_o),
        .b_o        (b_o)
    );

endmodule

// ==== sim/tb_clock.sv ====
/* Testbench clock and reset
   25 MHz clock with a 40 ns period, reset held low for four cycles */

`timescale 1ns/1ps

module tb_clock (
    output logic clock25_o,
    output logic reset_n_o
);

    // Half of the 40 ns period
    initial begin
        clock25_o = 1'b0;
        forever #20 clock25_o = ~clock25_o;
    end

    // Reset released on a falling edge, away from the DUT's sampling edge
    initial begin
        reset_n_o = 1'b0;
        repeat (4) @(posedge clock25_o);
        @(negedge clock25_o);
        reset_n_o = 1'b1;
    end

endmodule

// ==== sim/tb_ppu.sv ====
/* PPU testbench
   Directed tests of sync timing, CPU registers, palette, colour output and NMI */

`timescale 1ns/1ps

module tb_ppu;

    // ----------------------------------------
    // Frame timing and limits
    // ----------------------------------------
    localparam int CLOCK_NS     = 40;
    localparam int LINE_CLOCKS  = 800;
    localparam int FRAME_CLOCKS = 800 * 525;
    localparam int HS_LOW       = 96;
    localparam int VS_LOW       = 2 * 800;
    // Visible window after the back porches
    localparam int WIN_X0 = 48;
    localparam int WIN_X1 = 48 + 640;
    localparam int WIN_Y0 = 33;
    localparam int WIN_Y1 = 33 + 480;
    // Frame wrap puts two even lines in a row, so slots can be far apart
    localparam int SLOT_LIMIT = 4 * LINE_CLOCKS;
    // Frames per test: sync 3, accesses 1, colour 2, NMI 4
    localparam int TEST_FRAMES = 3 + 1 + 2 + 4;
    localparam longint WATCHDOG_NS = longint'(TEST_FRAMES) * FRAME_CLOCKS * CLOCK_NS;

    // RGB for the colour indices checked here
    localparam logic [11:0] RGB_BACKDROP = 12'h3BF;
    localparam logic [11:0] RGB_BLACK    = 12'h000;
    localparam logic [7:0]  BACKDROP_IDX = 8'h21;

    logic        clock25;
    logic        reset_n;
    logic [15:0] cpu_addr;
    logic [7:0]  cpu_wdata;
    logic        cpu_we;
    logic        cpu_re;
    logic [7:0]  cpu_rdata;
    logic        ce_cpu;
    logic        nmi;
    logic [3:0]  r;
    logic [3:0]  g;
    logic [3:0]  b;
    logic        hs;
    logic        vs;
    logic [31:0] lfsr_q;
    int          checks;
    int          errors;
    string       test_name;

    tb_clock u_clock (
        .clock25_o (clock25),
        .reset_n_o (reset_n)
    );

    ppu_top u_dut (
        .clock25     (clock25),
        .reset_n     (reset_n),
        .cpu_addr_i  (cpu_addr),
        .cpu_wdata_i (cpu_wdata),
        .cpu_we_i    (cpu_we),
        .cpu_re_i    (cpu_re),
        .cpu_rdata_o (cpu_rdata),
        .ce_cpu_o    (ce_cpu),
        .nmi_o       (nmi),
        .r_o         (r),
        .g_o         (g),
        .b_o         (b),
        .hs_o        (hs),
        .vs_o        (vs)
    );

    // ----------------------------------------
    // Checking and reporting
    // ----------------------------------------
    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error %s, %s: expected %0h, actual %0h", test_name, name,
                     expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%s", what);
    endtask

    task automatic finish_test(input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - errors_before);
        end
    endtask

    // ----------------------------------------
    // Random values
    // ----------------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_byte(output logic [7:0] value);
        for (int i = 0; i < 8; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            value  = {value[6:0], lfsr_q[0]};
        end
    endtask

    // ----------------------------------------
    // CPU accesses, one per slot pair
    // ----------------------------------------
    task automatic wait_cpu_slot();
        int n;
        n = 0;
        @(negedge clock25);
        while (!ce_cpu && n < SLOT_LIMIT) begin
            @(negedge clock25);
            n++;
        end
        if (!ce_cpu) begin
            report_failure("ce_cpu_o pulse did not arrive in time");
        end
    endtask

    // Request held until the next pulse
    task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
        wait_cpu_slot();
        cpu_addr  = addr;
        cpu_wdata = data;
        cpu_we    = 1'b1;
        wait_cpu_slot();
        cpu_we    = 1'b0;
    endtask

    // Result is valid by the next pulse
    task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
        wait_cpu_slot();
        cpu_addr = addr;
        cpu_re   = 1'b1;
        wait_cpu_slot();
        data     = cpu_rdata;
        cpu_re   = 1'b0;
    endtask

    // Status read first, so the high byte goes in first
    task automatic set_vram_addr(input logic [15:0] addr);
        logic [7:0] unused_status;
        cpu_read(16'h2002, unused_status);
        cpu_write(16'h2006, addr[15:8]);
        cpu_write(16'h2006, addr[7:0]);
    endtask

    // ----------------------------------------
    // Waiting on DUT outputs
    // ----------------------------------------
    function automatic logic sync_level(input int which);
        return (which == 0) ? hs : vs;
    endfunction

    task automatic measure_sync(input int which, input int limit,
                                output int low_len, output int period);
        logic prev;
        logic cur;
        logic found;
        logic in_low;
        int   n;
        low_len = 0;
        period  = 0;
        found   = 1'b0;
        n       = 0;
        prev    = sync_level(which);
        // Falling edge of the pulse
        while (!found && n < limit) begin
            @(negedge clock25);
            cur   = sync_level(which);
            found = prev && !cur;
            prev  = cur;
            n++;
        end
        if (!found) begin
            if (which == 0) begin
                report_failure("hs_o never fell");
            end else begin
                report_failure("vs_o never fell");
            end
            return;
        end
        low_len = 1;
        period  = 1;
        in_low  = 1'b1;
        found   = 1'b0;
        // Low time, then on to the next fall
        while (!found && period <= limit) begin
            @(negedge clock25);
            cur = sync_level(which);
            if (in_low && !cur) begin
                low_len++;
            end else begin
                in_low = 1'b0;
            end
            found = prev && !cur;
            if (!found) begin
                period++;
            end
            prev = cur;
        end
    endtask

    task automatic wait_nmi(input logic level, input int limit, output logic seen);
        int n;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(negedge clock25);
            seen = (nmi == level);
            n++;
        end
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic test_reset_state();
        int errors_before;
        errors_before = errors;
        test_name     = "reset";
        compare("ce_cpu_o after reset", 32'h0, 32'(ce_cpu));
        compare("nmi_o after reset", 32'h0, 32'(nmi));
        compare("rgb after reset", 32'(RGB_BLACK), 32'({r, g, b}));
        finish_test(errors_before);
    endtask

    task automatic test_sync();
        int errors_before;
        int low_len;
        int period;
        errors_before = errors;
        test_name     = "sync";
        measure_sync(0, 2 * LINE_CLOCKS, low_len, period);
        compare("hs low clocks", 32'(HS_LOW), 32'(low_len));
        compare("hs period", 32'(LINE_CLOCKS), 32'(period));
        measure_sync(1, 2 * FRAME_CLOCKS, low_len, period);
        compare("vs low clocks", 32'(VS_LOW), 32'(low_len));
        compare("vs period", 32'(FRAME_CLOCKS), 32'(period));
        finish_test(errors_before);
    endtask

    task automatic test_registers();
        int         errors_before;
        logic [7:0] data;
        errors_before = errors;
        test_name     = "registers";
        cpu_read(16'h2000, data);
        compare("ctrl reset value", 32'h10, 32'(data));
        cpu_read(16'h2001, data);
        compare("mask reset value", 32'h0E, 32'(data));
        cpu_write(16'h2000, 8'h24);
        cpu_read(16'h2000, data);
        compare("ctrl readback", 32'h24, 32'(data));
        cpu_write(16'h2001, 8'h1E);
        cpu_read(16'h2001, data);
        compare("mask readback", 32'h1E, 32'(data));
        // Outside $2000-$3FFF nothing answers
        cpu_write(16'h4000, 8'h5A);
        cpu_read(16'h4000, data);
        compare("unmapped read", 32'h0, 32'(data));
        cpu_write(16'h2000, 8'h00);
        finish_test(errors_before);
    endtask

    task automatic test_palette();
        int         errors_before;
        logic [7:0] written [8];
        logic [7:0] value;
        logic [7:0] first;
        logic [7:0] data;
        errors_before = errors;
        test_name     = "palette";
        set_vram_addr(16'h3F00);
        for (int i = 0; i < 8; i++) begin
            random_byte(value);
            written[i] = value;
            cpu_write(16'h2007, value);
        end
        set_vram_addr(16'h3F00);
        for (int i = 0; i < 8; i++) begin
            cpu_read(16'h2007, data);
            compare($sformatf("palette entry %0d", i), 32'(written[i] & 8'h3F), 32'(data));
        end

        // Step of 32: second write hits $3F20, outside the palette
        cpu_write(16'h2000, 8'h04);
        set_vram_addr(16'h3F00);
        random_byte(first);
        cpu_write(16'h2007, first);
        random_byte(value);
        cpu_write(16'h2007, value);
        set_vram_addr(16'h3F00);
        cpu_read(16'h2007, data);
        compare("entry 0 with step 32", 32'(first & 8'h3F), 32'(data));
        cpu_read(16'h2007, data);
        compare("read at 3F20", 32'h0, 32'(data));
        cpu_write(16'h2000, 8'h00);
        finish_test(errors_before);
    endtask

    task automatic test_colour();
        int          errors_before;
        int          x;
        int          y;
        int          n;
        int          bad;
        logic        found;
        logic        prev_vs;
        logic        prev_active;
        logic [11:0] expected;
        errors_before = errors;
        test_name     = "colour";
        set_vram_addr(16'h3F00);
        cpu_write(16'h2007, BACKDROP_IDX);

        // vs_o rises as the beam enters x = 0, y = 0
        found   = 1'b0;
        n       = 0;
        prev_vs = vs;
        while (!found && n < 2 * FRAME_CLOCKS) begin
            @(negedge clock25);
            found   = vs && !prev_vs;
            prev_vs = vs;
            n++;
        end
        if (!found) begin
            report_failure("vs_o never rose during the colour test");
        end else begin
            x           = 0;
            y           = 0;
            bad         = 0;
            // Last position of the previous frame is blanking
            prev_active = 1'b0;
            for (int i = 0; i < FRAME_CLOCKS && bad < 8; i++) begin
                // Output shows the position one clock back
                expected = prev_active ? RGB_BACKDROP : RGB_BLACK;
                if ({r, g, b} !== expected) begin
                    bad++;
                end
                compare($sformatf("rgb at x %0d y %0d", x, y), 32'(expected), 32'({r, g, b}));
                prev_active = (x >= WIN_X0) && (x < WIN_X1) && (y >= WIN_Y0) && (y < WIN_Y1);
                x++;
                if (x == LINE_CLOCKS) begin
                    x = 0;
                    y++;
                end
                @(negedge clock25);
            end
        end
        finish_test(errors_before);
    endtask

    task automatic test_vblank_nmi();
        int         errors_before;
        logic       seen;
        logic [7:0] data;
        errors_before = errors;
        test_name     = "vblank and nmi";
        cpu_write(16'h2000, 8'h80);
        wait_nmi(1'b1, 2 * FRAME_CLOCKS, seen);
        if (!seen) begin
            report_failure("nmi_o did not rise with NMI enabled");
        end
        // Vblank set, bit 4 fixed, sprite flags clear
        cpu_read(16'h2002, data);
        compare("status in vblank", 32'h90, 32'(data));
        cpu_read(16'h2002, data);
        compare("status after read", 32'h10, 32'(data));
        wait_nmi(1'b0, FRAME_CLOCKS, seen);
        if (!seen) begin
            report_failure("nmi_o did not fall before the next frame");
        end
        // Disabled for a whole frame
        cpu_write(16'h2000, 8'h00);
        wait_nmi(1'b1, FRAME_CLOCKS, seen);
        if (seen) begin
            report_failure("nmi_o rose with NMI disabled");
        end
        finish_test(errors_before);
    endtask

    // ----------------------------------------
    // Run
    // ----------------------------------------
    initial begin
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_we    = 1'b0;
        cpu_re    = 1'b0;
        checks    = 0;
        errors    = 0;
        lfsr_q    = 32'h8d51;
        test_name = "";
        wait (reset_n);
        @(negedge clock25);
        test_reset_state();
        test_sync();
        test_registers();
        test_palette();
        test_colour();
        test_vblank_nmi();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Budget from the frames each test needs
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== compile.f ====
src/ppu_pkg.sv
src/ppu_if.sv
src/vga_timing.sv
src/ppu_cpu_regs.sv
src/ppu_palette.sv
src/ppu_color_out.sv
src/ppu_top.sv
sim/tb_clock.sv
sim/tb_ppu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the PPU testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module tb_ppu -Mdir "$BUILD_DIR" -o tb_ppu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_ppu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The log decides the result
if grep -q "Checks failed" "$LOG"; then
    exit 1
fi
exit 0
